//--- bench/rob_tb.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module rob_tb;
	import rob_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES = 300;
	localparam int WAIT_LIMIT = 200;
	localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD;

	logic clk;
	logic reset;
	dispatch_t dispatch;
	logic dispatch_ready;
	rob_tag_t dispatch_tag;
	complete_t complete;
	retire_t retire;
	logic redirect_valid;
	logic [31:0] redirect_pc;
	apb_req_t apb_req;
	apb_resp_t apb_resp;

	integer seed = 52;

	// APB slave memory and its state
	logic [31:0] mem [256];
	apb_req_t bus_req_s;
	logic pready_s;
	int wait_cnt;

	// what the DUT retired and wrote
	logic [4:0] ret_dst_q[$];
	logic [31:0] ret_value_q[$];
	logic [31:0] ret_pc_q[$];
	entry_kind_e ret_kind_q[$];
	logic [31:0] redirect_q[$];
	logic [31:0] wr_addr_q[$];
	logic [31:0] wr_data_q[$];

	rob_top DUT (
		.clk,
		.reset,
		.dispatch,
		.dispatch_ready,
		.dispatch_tag,
		.complete,
		.retire,
		.redirect_valid,
		.redirect_pc,
		.apb_req,
		.apb_resp
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] mem_preset(int idx);
		return 32'h6b000000 | (idx << 12) | (idx ^ 8'h5a);
	endfunction

	function automatic rob_result_u alu_res(logic [31:0] v);
		rob_result_u r;
		r = '0;
		r.alu.value = v;
		return r;
	endfunction

	function automatic rob_result_u branch_res(logic mispredict, logic [31:0] target);
		rob_result_u r;
		r = '0;
		r.branch.mispredict = mispredict;
		r.branch.target = target;
		return r;
	endfunction

	function automatic rob_result_u mem_res(logic [31:0] addr, logic [31:0] data);
		rob_result_u r;
		r = '0;
		r.mem.addr = addr;
		r.mem.data = data;
		return r;
	endfunction

	task automatic abort_run(input string why);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0d ns: %s got %h, expected %h", $time, what, actual, expected);
			abort_run("stopped at the first mismatch");
		end
	endtask

	// slave samples at negedge and answers just after the rising edge
	always begin
		@(negedge clk);
		bus_req_s = apb_req;
		pready_s = apb_resp.pready;
		@(posedge clk);
		#1;
		if (reset) begin
			apb_resp = '0;
			wait_cnt = 0;
		end else if (bus_req_s.psel && !bus_req_s.penable) begin
			wait_cnt = $unsigned($random(seed)) % 4;
			if (wait_cnt == 0) begin
				apb_resp.prdata = mem[bus_req_s.paddr[9:2]];
				apb_resp.pready = 1'b1;
			end
		end else if (bus_req_s.psel && pready_s) begin
			// transfer finished at this edge
			if (bus_req_s.pwrite) begin
				// byte lanes follow the write strobes
				for (int b = 0; b < 4; b++) begin
					if (bus_req_s.pstrb[b]) begin
						mem[bus_req_s.paddr[9:2]][8*b +: 8] = bus_req_s.pwdata[8*b +: 8];
					end
				end
				wr_addr_q.push_back(bus_req_s.paddr);
				wr_data_q.push_back(mem[bus_req_s.paddr[9:2]]);
			end
			apb_resp.pready = 1'b0;
		end else if (bus_req_s.psel) begin
			wait_cnt--;
			if (wait_cnt <= 0) begin
				apb_resp.prdata = mem[bus_req_s.paddr[9:2]];
				apb_resp.pready = 1'b1;
			end
		end
	end

	// retire monitor samples at negedge where outputs are settled
	always @(negedge clk) begin
		if (!reset && retire.valid) begin
			ret_dst_q.push_back(retire.dst);
			ret_value_q.push_back(retire.value);
			ret_pc_q.push_back(retire.pc);
			ret_kind_q.push_back(retire.kind);
		end
		if (!reset && redirect_valid) begin
			redirect_q.push_back(redirect_pc);
		end
	end

	task automatic clear_logs();
		ret_dst_q.delete();
		ret_value_q.delete();
		ret_pc_q.delete();
		ret_kind_q.delete();
		redirect_q.delete();
		wr_addr_q.delete();
		wr_data_q.delete();
	endtask

	// tasks below start and end one step after a rising edge
	task automatic dispatch_one(input entry_kind_e kind, input logic [4:0] dst,
			input logic [31:0] pc, output rob_tag_t tag);
		int waited;
		waited = 0;
		dispatch.valid = 1'b1;
		dispatch.kind = kind;
		dispatch.dst = dst;
		dispatch.pc = pc;
		@(negedge clk);
		while (!dispatch_ready) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				abort_run("dispatch was never accepted");
			end
			@(negedge clk);
		end
		tag = dispatch_tag;
		@(posedge clk);
		#1;
		dispatch = '0;
	endtask

	task automatic complete_one(input rob_tag_t tag, input rob_result_u result);
		complete.valid = 1'b1;
		complete.tag = tag;
		complete.result = result;
		@(posedge clk);
		#1;
		complete = '0;
	endtask

	task automatic wait_retires(input int n);
		int cycles;
		cycles = 0;
		while (ret_value_q.size() < n) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run("expected retirements did not happen in time");
			end
		end
	endtask

	task automatic wait_writes(input int n);
		int cycles;
		cycles = 0;
		while (wr_addr_q.size() < n) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run("store writes did not reach the APB slave in time");
			end
		end
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		check_value(dispatch_ready, 1'b1, "dispatch_ready after reset");
		check_value(retire.valid, 1'b0, "retire.valid after reset");
		check_value(redirect_valid, 1'b0, "redirect_valid after reset");
		check_value(apb_req.psel, 1'b0, "psel after reset");
		@(posedge clk);
		#1;
	endtask

	task automatic test_out_of_order();
		rob_tag_t tags[5];
		clear_logs();
		for (int i = 0; i < 5; i++) begin
			dispatch_one(KIND_ALU, 5'(i + 1), 32'h100 + 4 * i, tags[i]);
		end
		for (int i = 4; i >= 0; i--) begin
			complete_one(tags[i], alu_res(32'ha000 + i));
		end
		wait_retires(5);
		for (int i = 0; i < 5; i++) begin
			check_value(ret_dst_q[i], 5'(i + 1), "in-order retire dst");
			check_value(ret_value_q[i], 32'ha000 + i, "in-order retire value");
			check_value(ret_pc_q[i], 32'h100 + 4 * i, "in-order retire pc");
			check_value(ret_kind_q[i], KIND_ALU, "in-order retire kind");
		end
	endtask

	task automatic test_full();
		rob_tag_t tags[$];
		int accepts;
		logic stop;
		clear_logs();
		accepts = 0;
		stop = 1'b0;
		dispatch.valid = 1'b1;
		dispatch.kind = KIND_ALU;
		dispatch.dst = 5'd9;
		dispatch.pc = 32'h200;
		while (!stop) begin
			@(negedge clk);
			if (dispatch_ready && accepts <= `ROB_DEPTH) begin
				tags.push_back(dispatch_tag);
				accepts++;
			end else begin
				stop = 1'b1;
			end
			@(posedge clk);
			#1;
		end
		dispatch = '0;
		check_value(accepts, `ROB_DEPTH, "accepts before full");
		complete_one(tags[0], alu_res(32'h3000));
		wait_retires(1);
		@(negedge clk);
		check_value(dispatch_ready, 1'b1, "dispatch_ready after one retire");
		@(posedge clk);
		#1;
		// drain what is left
		for (int i = 1; i < `ROB_DEPTH; i++) begin
			complete_one(tags[i], alu_res(32'h3000 + i));
		end
		wait_retires(`ROB_DEPTH);
		for (int i = 0; i < `ROB_DEPTH; i++) begin
			check_value(ret_value_q[i], 32'h3000 + i, "value after full drain");
		end
	endtask

	task automatic test_mispredict();
		rob_tag_t t_alu;
		rob_tag_t t_br;
		rob_tag_t t_y0;
		rob_tag_t t_y1;
		rob_tag_t t_new;
		rob_tag_t expect_tag;
		clear_logs();
		dispatch_one(KIND_ALU, 5'd3, 32'h400, t_alu);
		dispatch_one(KIND_BRANCH, 5'd0, 32'h404, t_br);
		dispatch_one(KIND_ALU, 5'd4, 32'h408, t_y0);
		dispatch_one(KIND_ALU, 5'd5, 32'h40c, t_y1);
		complete_one(t_y0, alu_res(32'hbad0));
		complete_one(t_y1, alu_res(32'hbad1));
		complete_one(t_alu, alu_res(32'h1234));
		complete_one(t_br, branch_res(1'b1, 32'h8000));
		wait_retires(2);
		repeat (8) begin
			@(posedge clk);
			#1;
		end
		check_value(ret_value_q.size(), 2, "retire count after flush");
		check_value(ret_dst_q[0], 5'd3, "alu before branch dst");
		check_value(ret_value_q[0], 32'h1234, "alu before branch value");
		check_value(ret_pc_q[1], 32'h404, "branch retire pc");
		check_value(ret_kind_q[1], KIND_BRANCH, "branch retire kind");
		check_value(redirect_q.size(), 1, "redirect count");
		check_value(redirect_q[0], 32'h8000, "redirect_pc");
		expect_tag = t_br + 1'b1;
		dispatch_one(KIND_ALU, 5'd6, 32'h8000, t_new);
		check_value(t_new, expect_tag, "tag after flush");
		complete_one(t_new, alu_res(32'h5555));
		wait_retires(3);
		check_value(ret_dst_q[2], 5'd6, "first retire after redirect dst");
		check_value(ret_value_q[2], 32'h5555, "first retire after redirect value");
	endtask

	task automatic test_stores();
		logic [31:0] addrs[3];
		logic [31:0] datas[3];
		rob_tag_t tag;
		clear_logs();
		addrs = '{32'h40, 32'h84, 32'h3f0};
		datas = '{32'h11112222, 32'h33334444, 32'h55556666};
		for (int i = 0; i < 3; i++) begin
			dispatch_one(KIND_STORE, 5'd0, 32'h500 + 4 * i, tag);
			complete_one(tag, mem_res(addrs[i], datas[i]));
		end
		wait_retires(3);
		wait_writes(3);
		for (int i = 0; i < 3; i++) begin
			check_value(ret_kind_q[i], KIND_STORE, "store retire kind");
			check_value(wr_addr_q[i], addrs[i], "store write address");
			check_value(wr_data_q[i], datas[i], "store write data");
		end
	endtask

	task automatic test_load_after_store();
		rob_tag_t t_st;
		rob_tag_t t_ld;
		clear_logs();
		dispatch_one(KIND_STORE, 5'd0, 32'h600, t_st);
		dispatch_one(KIND_UNCACHED_LOAD, 5'd7, 32'h604, t_ld);
		complete_one(t_st, mem_res(32'h120, 32'hdeadbeef));
		complete_one(t_ld, mem_res(32'h120, 32'h0));
		wait_retires(2);
		check_value(ret_dst_q[1], 5'd7, "load dst");
		check_value(ret_kind_q[1], KIND_UNCACHED_LOAD, "load retire kind");
		check_value(ret_value_q[1], 32'hdeadbeef, "load after store value");
		// untouched word returns the preset
		dispatch_one(KIND_UNCACHED_LOAD, 5'd8, 32'h608, t_ld);
		complete_one(t_ld, mem_res(32'h2c4, 32'h0));
		wait_retires(3);
		check_value(ret_dst_q[2], 5'd8, "preset load dst");
		check_value(ret_value_q[2], mem_preset(32'h2c4 >> 2), "preset load value");
	endtask

	initial begin
		#(WATCHDOG_NS);
		abort_run("watchdog timeout, the tests did not finish in time");
	end

	initial begin
		reset = 1'b1;
		dispatch = '0;
		complete = '0;
		apb_resp = '0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = mem_preset(i);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset_state();
		test_out_of_order();
		test_full();
		test_mispredict();
		test_stores();
		test_load_after_store();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+logic
logic/rob_pkg.sv
logic/rob_ram.sv
logic/reorder_buffer.sv
logic/store_buffer.sv
logic/apb_arbiter.sv
logic/rob_top.sv
bench/rob_tb.sv

//--- logic/apb_arbiter.sv
`timescale 1ns/1ps

module apb_arbiter (
	input  logic               clk,
	input  logic               reset,
	input  rob_pkg::apb_req_t  req0,
	output rob_pkg::apb_resp_t resp0,
	input  rob_pkg::apb_req_t  req1,
	output rob_pkg::apb_resp_t resp1,
	output rob_pkg::apb_req_t  bus_req,
	input  rob_pkg::apb_resp_t bus_resp
);
	logic locked;
	logic owner;
	logic last;
	logic sel;
	logic any_req;

	assign any_req = req0.psel | req1.psel;

	// the port that did not win last goes first
	always_comb begin
		if (locked) begin
			sel = owner;
		end else if (req0.psel && req1.psel) begin
			sel = ~last;
		end else begin
			sel = req1.psel;
		end
	end

	// grant cycle is the bus setup phase, locked cycles are access
	always_comb begin
		bus_req = '0;
		if (locked || any_req) begin
			bus_req = sel ? req1 : req0;
			bus_req.psel = 1'b1;
			bus_req.penable = locked;
		end
	end

	// a port that is not the owner keeps waiting
	always_comb begin
		resp0 = bus_resp;
		resp1 = bus_resp;
		resp0.pready = locked & ~owner & bus_resp.pready;
		resp1.pready = locked & owner & bus_resp.pready;
		resp0.pslverr = locked & ~owner & bus_resp.pslverr;
		resp1.pslverr = locked & owner & bus_resp.pslverr;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			locked <= 1'b0;
			owner <= 1'b0;
			last <= 1'b1;
		end else if (!locked) begin
			if (any_req) begin
				locked <= 1'b1;
				owner <= sel;
			end
		end else if (bus_resp.pready) begin
			locked <= 1'b0;
			last <= owner;
		end
	end

endmodule

//--- logic/reorder_buffer.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module reorder_buffer (
	input  logic                 clk,
	input  logic                 reset,
	input  rob_pkg::dispatch_t   dispatch,
	output logic                 dispatch_ready,
	output rob_pkg::rob_tag_t    dispatch_tag,
	input  rob_pkg::complete_t   complete,
	output rob_pkg::retire_t     retire,
	output logic                 redirect_valid,
	output logic [31:0]          redirect_pc,
	output rob_pkg::mem_result_t sb_push,
	output logic                 sb_push_valid,
	input  logic                 sb_ready,
	output logic [31:0]          ld_addr,
	input  logic                 ld_conflict,
	output rob_pkg::apb_req_t    ld_req,
	input  rob_pkg::apb_resp_t   ld_resp
);
	import rob_pkg::*;

	localparam int TAG_W = $clog2(`ROB_DEPTH);

	// extra msb tells full from empty
	logic [TAG_W:0] head;
	logic [TAG_W:0] tail;
	rob_tag_t head_idx;
	rob_tag_t tail_idx;
	logic [`ROB_DEPTH-1:0] done;

	logic full;
	logic empty;
	logic dispatch_fire;
	logic head_done;
	logic retire_fire;

	rob_entry_t info_wdata;
	rob_entry_t info_rdata;
	rob_entry_t result_wdata;
	rob_entry_t result_rdata;
	entry_kind_e head_kind;
	rob_result_u head_result;

	apb_phase_e ld_state;
	apb_phase_e ld_state_next;

	assign head_idx = head[TAG_W-1:0];
	assign tail_idx = tail[TAG_W-1:0];
	assign full = (head[TAG_W] != tail[TAG_W]) && (head_idx == tail_idx);
	assign empty = (head == tail);

	// no allocation while the tail is being pulled back
	assign dispatch_ready = ~full & ~redirect_valid;
	assign dispatch_tag = tail_idx;
	assign dispatch_fire = dispatch.valid & dispatch_ready;

	// static fields at dispatch
	always_comb begin
		info_wdata = '0;
		info_wdata.kind = dispatch.kind;
		info_wdata.dst = dispatch.dst;
		info_wdata.pc = dispatch.pc;
	end

	// result at completion, only the union part is read back
	always_comb begin
		result_wdata = '0;
		result_wdata.result = complete.result;
	end

	rob_ram info_ram (
		.clk,
		.we(dispatch_fire),
		.waddr(tail_idx),
		.wdata(info_wdata),
		.raddr(head_idx),
		.rdata(info_rdata)
	);

	rob_ram result_ram (
		.clk,
		.we(complete.valid),
		.waddr(complete.tag),
		.wdata(result_wdata),
		.raddr(head_idx),
		.rdata(result_rdata)
	);

	assign head_kind = info_rdata.kind;
	assign head_result = result_rdata.result;
	assign head_done = ~empty & done[head_idx];

	// head retirement by kind
	always_comb begin
		retire_fire = 1'b0;
		redirect_valid = 1'b0;
		sb_push_valid = 1'b0;
		if (head_done) begin
			case (head_kind)
				KIND_ALU: begin
					retire_fire = 1'b1;
				end
				KIND_BRANCH: begin
					retire_fire = 1'b1;
					redirect_valid = head_result.branch.mispredict;
				end
				KIND_STORE: begin
					sb_push_valid = 1'b1;
					retire_fire = sb_ready;
				end
				default: begin
					// uncached load leaves with the read data
					retire_fire = (ld_state == APB_ACCESS) & ld_resp.pready;
				end
			endcase
		end
	end

	always_comb begin
		retire.valid = retire_fire;
		retire.kind = head_kind;
		retire.dst = info_rdata.dst;
		retire.pc = info_rdata.pc;
		case (head_kind)
			KIND_ALU: retire.value = head_result.alu.value;
			KIND_UNCACHED_LOAD: retire.value = ld_resp.prdata;
			default: retire.value = '0;
		endcase
	end

	assign redirect_pc = head_result.branch.target;
	assign sb_push = head_result.mem;
	assign ld_addr = head_result.mem.addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			done <= '0;
		end else begin
			if (retire_fire) begin
				head <= head + 1'b1;
			end
			// flush drops everything younger than the branch
			if (redirect_valid) begin
				tail <= head + 1'b1;
			end else if (dispatch_fire) begin
				tail <= tail + 1'b1;
			end
			if (dispatch_fire) begin
				done[tail_idx] <= 1'b0;
			end
			if (complete.valid) begin
				done[complete.tag] <= 1'b1;
			end
		end
	end

	// uncached load runs setup then access
	always_comb begin
		ld_state_next = ld_state;
		case (ld_state)
			APB_IDLE: begin
				if (head_done && head_kind == KIND_UNCACHED_LOAD && !ld_conflict) begin
					ld_state_next = APB_SETUP;
				end
			end
			APB_SETUP: ld_state_next = APB_ACCESS;
			APB_ACCESS: begin
				if (ld_resp.pready) begin
					ld_state_next = APB_IDLE;
				end
			end
			default: ld_state_next = APB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ld_state <= APB_IDLE;
		end else begin
			ld_state <= ld_state_next;
		end
	end

	// read transfer, strobes stay low
	always_comb begin
		ld_req = '0;
		ld_req.psel = (ld_state != APB_IDLE);
		ld_req.penable = (ld_state == APB_ACCESS);
		ld_req.paddr = head_result.mem.addr;
	end

endmodule

//--- logic/rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// reorder buffer entries, a power of two
// tags are log2 of this wide
`define ROB_DEPTH 8

// retired stores waiting for their APB write
`define SB_DEPTH 4

// data and address width
`define XLEN 32

`endif

//--- logic/rob_pkg.sv
`include "rob_config.svh"

package rob_pkg;

	typedef enum logic [1:0] {
		KIND_ALU,
		KIND_BRANCH,
		KIND_STORE,
		KIND_UNCACHED_LOAD
	} entry_kind_e;

	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

	// phase of one requester's own APB transfer
	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apb_phase_e;

	typedef struct packed {
		logic [31:0]      unused;
		logic [`XLEN-1:0] value;
	} alu_result_t;

	typedef struct packed {
		logic             mispredict;
		logic [30:0]      unused;
		logic [`XLEN-1:0] target;
	} branch_result_t;

	typedef struct packed {
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] data;
	} mem_result_t;

	// view picked by the kind of the owning entry
	typedef union packed {
		alu_result_t    alu;
		branch_result_t branch;
		mem_result_t    mem;
	} rob_result_u;

	typedef struct packed {
		logic             valid;
		entry_kind_e      kind;
		logic [4:0]       dst;
		logic [`XLEN-1:0] pc;
	} dispatch_t;

	typedef struct packed {
		logic        valid;
		rob_tag_t    tag;
		rob_result_u result;
	} complete_t;

	typedef struct packed {
		logic             valid;
		entry_kind_e      kind;
		logic [4:0]       dst;
		logic [`XLEN-1:0] value;
		logic [`XLEN-1:0] pc;
	} retire_t;

	typedef struct packed {
		logic             psel;
		logic             penable;
		logic             pwrite;
		logic [`XLEN-1:0] paddr;
		logic [`XLEN-1:0] pwdata;
		logic [3:0]       pstrb;
	} apb_req_t;

	typedef struct packed {
		logic [`XLEN-1:0] prdata;
		logic             pready;
		logic             pslverr;
	} apb_resp_t;

	typedef struct packed {
		entry_kind_e      kind;
		logic [4:0]       dst;
		logic [`XLEN-1:0] pc;
		rob_result_u      result;
	} rob_entry_t;

endpackage

//--- logic/rob_ram.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module rob_ram (
	input  logic                clk,
	input  logic                we,
	input  rob_pkg::rob_tag_t   waddr,
	input  rob_pkg::rob_entry_t wdata,
	input  rob_pkg::rob_tag_t   raddr,
	output rob_pkg::rob_entry_t rdata
);
	import rob_pkg::*;

	rob_entry_t mem [`ROB_DEPTH];

	// one write per cycle
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// read is async so the head entry is visible in the same cycle
	assign rdata = mem[raddr];

endmodule

//--- logic/rob_top.sv
`timescale 1ns/1ps

module rob_top (
	input  logic               clk,
	input  logic               reset,
	input  rob_pkg::dispatch_t dispatch,
	output logic               dispatch_ready,
	output rob_pkg::rob_tag_t  dispatch_tag,
	input  rob_pkg::complete_t complete,
	output rob_pkg::retire_t   retire,
	output logic               redirect_valid,
	output logic [31:0]        redirect_pc,
	output rob_pkg::apb_req_t  apb_req,
	input  rob_pkg::apb_resp_t apb_resp
);
	import rob_pkg::*;

	apb_req_t ld_req;
	apb_resp_t ld_resp;
	apb_req_t st_req;
	apb_resp_t st_resp;
	mem_result_t sb_push;
	logic sb_push_valid;
	logic sb_ready;
	logic [31:0] ld_addr;
	logic ld_conflict;

	reorder_buffer rob (
		.clk,
		.reset,
		.dispatch,
		.dispatch_ready,
		.dispatch_tag,
		.complete,
		.retire,
		.redirect_valid,
		.redirect_pc,
		.sb_push,
		.sb_push_valid,
		.sb_ready,
		.ld_addr,
		.ld_conflict,
		.ld_req,
		.ld_resp
	);

	store_buffer sb (
		.clk,
		.reset,
		.push(sb_push),
		.push_valid(sb_push_valid),
		.ready(sb_ready),
		.ld_addr,
		.ld_conflict,
		.apb_req(st_req),
		.apb_resp(st_resp)
	);

	// load port on 0, store drain on 1
	apb_arbiter arb (
		.clk,
		.reset,
		.req0(ld_req),
		.resp0(ld_resp),
		.req1(st_req),
		.resp1(st_resp),
		.bus_req(apb_req),
		.bus_resp(apb_resp)
	);

endmodule

//--- logic/store_buffer.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module store_buffer (
	input  logic                 clk,
	input  logic                 reset,
	input  rob_pkg::mem_result_t push,
	input  logic                 push_valid,
	output logic                 ready,
	input  logic [31:0]          ld_addr,
	output logic                 ld_conflict,
	output rob_pkg::apb_req_t    apb_req,
	input  rob_pkg::apb_resp_t   apb_resp
);
	import rob_pkg::*;

	localparam int PTR_W = $clog2(`SB_DEPTH);

	logic [31:0] addr_q [`SB_DEPTH];
	logic [31:0] data_q [`SB_DEPTH];
	logic [`SB_DEPTH-1:0] vld;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_next;
	logic push_fire;
	logic drain_done;
	apb_phase_e state;
	apb_phase_e state_next;

	// next write slot still occupied means full
	assign ready = ~vld[wr_ptr];
	assign push_fire = push_valid & ready;
	assign drain_done = (state == APB_ACCESS) & apb_resp.pready;
	assign rd_next = rd_ptr + 1'b1;

	always_comb begin
		state_next = state;
		case (state)
			APB_IDLE: begin
				if (vld[rd_ptr] || push_fire) begin
					state_next = APB_SETUP;
				end
			end
			APB_SETUP: state_next = APB_ACCESS;
			APB_ACCESS: begin
				// back to back when another store is waiting
				if (apb_resp.pready) begin
					state_next = (vld[rd_next] || push_fire) ? APB_SETUP : APB_IDLE;
				end
			end
			default: state_next = APB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (push_fire) begin
			addr_q[wr_ptr] <= push.addr;
			data_q[wr_ptr] <= push.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			vld <= '0;
			rd_ptr <= '0;
			wr_ptr <= '0;
			state <= APB_IDLE;
		end else begin
			state <= state_next;
			if (push_fire) begin
				vld[wr_ptr] <= 1'b1;
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (drain_done) begin
				vld[rd_ptr] <= 1'b0;
				rd_ptr <= rd_next;
			end
		end
	end

	// word match against every pending store
	always_comb begin
		ld_conflict = 1'b0;
		for (int i = 0; i < `SB_DEPTH; i++) begin
			if (vld[i] && addr_q[i][31:2] == ld_addr[31:2]) begin
				ld_conflict = 1'b1;
			end
		end
	end

	always_comb begin
		apb_req.psel = (state != APB_IDLE);
		apb_req.penable = (state == APB_ACCESS);
		apb_req.pwrite = 1'b1;
		apb_req.paddr = addr_q[rd_ptr];
		apb_req.pwdata = data_q[rd_ptr];
		apb_req.pstrb = 4'hf;
	end

endmodule
